// File: common/chol_pkg.sv
`default_nettype none

package chol_pkg;

    // Matrix and number format
    // --------------------
    localparam int MAT_N     = 5;                       // Matrix order
    localparam int FRAC_BITS = 16;                      // Q16.16
    localparam int WORD_BITS = 32;
    localparam int NUM_ELEMS = MAT_N * (MAT_N + 1) / 2; // Lower triangle incl. diagonal

    // Iteration counts of the serial units
    localparam int SQRT_STEPS = (WORD_BITS + FRAC_BITS) / 2; // One root bit per step
    localparam int DIV_STEPS  = WORD_BITS + FRAC_BITS;       // One quotient bit per step

    typedef logic signed [WORD_BITS-1:0] q16_t;
    typedef logic [2:0]                  idx_t;  // Zero-based row or column

    // Lower triangle in row order: 11, 21, 22, 31, 32, 33, ... 55
    // elem[0] sits in the low word of flat
    typedef union packed {
        logic [NUM_ELEMS*WORD_BITS-1:0] flat;
        q16_t [NUM_ELEMS-1:0]           elem;
    } tri_mat_u;

    // Request to the dot-product unit
    // Result is base minus sum of L[row][k] * L[col][k] for k below col
    typedef struct packed {
        q16_t base;
        idx_t row;
        idx_t col;
    } dot_req_t;

    // Position of (row, col) in the packed triangle, row >= col
    function automatic logic [3:0] tri_idx(idx_t row, idx_t col);
        logic [4:0] r;
        logic [4:0] pos;
        r   = {2'b00, row};
        pos = ((r * (r + 5'd1)) >> 1) + {2'b00, col};
        return pos[3:0];
    endfunction

endpackage

`default_nettype wire

// File: arith/fix_sqrt.sv
`timescale 1ns/1ns
`default_nettype none

module fix_sqrt import chol_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  q16_t operand,
    output logic done,
    output q16_t result
);

    logic [2*SQRT_STEPS-1:0] rad;       // Radicand, consumed two bits per step
    logic [SQRT_STEPS+1:0]   rem;
    logic [SQRT_STEPS-1:0]   root;
    logic [4:0]              cnt;
    logic                    busy;

    logic [2*SQRT_STEPS-1:0] cur_rad;
    logic [SQRT_STEPS+1:0]   cur_rem;
    logic [SQRT_STEPS-1:0]   cur_root;
    logic [SQRT_STEPS+1:0]   rem_sh;
    logic [SQRT_STEPS+1:0]   trial;
    logic                    fits;

    // One restoring step, seeded from the operand on start
    always_comb begin
        if (start) begin
            cur_rad  = operand[WORD_BITS-1] ? '0 : {operand, {FRAC_BITS{1'b0}}};  // Negative -> 0
            cur_rem  = '0;
            cur_root = '0;
        end else begin
            cur_rad  = rad;
            cur_rem  = rem;
            cur_root = root;
        end
        rem_sh = {cur_rem[SQRT_STEPS-1:0], cur_rad[2*SQRT_STEPS-1 -: 2]};
        trial  = {cur_root, 2'b01};  // 4q + 1
        fits   = (rem_sh >= trial);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= 5'd1;  // First step runs on the start edge
            end else if (busy) begin
                cnt <= cnt + 5'd1;
                if (cnt == 5'(SQRT_STEPS - 1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start || busy) begin
            rad  <= {cur_rad[2*SQRT_STEPS-3:0], 2'b00};
            rem  <= fits ? rem_sh - trial : rem_sh;
            root <= {cur_root[SQRT_STEPS-2:0], fits};
        end
    end

    assign result = {{(WORD_BITS - SQRT_STEPS){1'b0}}, root};

endmodule

`default_nettype wire

// File: arith/fix_div.sv
`timescale 1ns/1ns
`default_nettype none

module fix_div import chol_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  q16_t dividend,
    input  q16_t divisor,
    output logic done,
    output q16_t result
);

    logic [DIV_STEPS-1:0] num;   // Dividend bits shift out, quotient bits shift in
    logic [WORD_BITS:0]   rem;
    logic [WORD_BITS-1:0] dvs;
    logic                 neg;
    logic [5:0]           cnt;
    logic                 busy;

    logic [WORD_BITS-1:0] mag;
    logic [WORD_BITS:0]   rem_sh;
    logic                 fits;
    logic [DIV_STEPS-1:0] quo;
    logic                 last;

    assign mag    = dividend[WORD_BITS-1] ? -dividend : dividend;  // Magnitude, unsigned
    assign rem_sh = {rem[WORD_BITS-1:0], num[DIV_STEPS-1]};
    assign fits   = (rem_sh >= {1'b0, dvs});
    assign quo    = {num[DIV_STEPS-2:0], fits};
    assign last   = (cnt == 6'(DIV_STEPS - 1));

    // Control
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt + 6'd1;
                if (last) begin
                    busy <= 1'b0;
                    done <= 1'b1;  // Result register loads on this same edge
                end
            end
        end
    end

    // Datapath
    // --------------------
    always_ff @(posedge clk) begin
        if (start) begin
            num <= {mag, {FRAC_BITS{1'b0}}};  // Pre-shift keeps 16 fraction bits
            rem <= '0;
            dvs <= divisor;
            neg <= dividend[WORD_BITS-1];
        end else if (busy) begin
            num <= quo;
            rem <= fits ? rem_sh - {1'b0, dvs} : rem_sh;
            if (last) begin
                if (dvs == '0) begin
                    result <= '0;                        // Zero divisor
                end else if (neg) begin
                    result <= -quo[WORD_BITS-1:0];       // Toward zero
                end else begin
                    result <= quo[WORD_BITS-1:0];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/chol_dot.sv
`timescale 1ns/1ns
`default_nettype none

module chol_dot import chol_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     start,
    input  dot_req_t req,
    input  tri_mat_u l_cur,
    output logic     done,
    output q16_t     result
);

    q16_t acc;
    idx_t row;
    idx_t col;
    idx_t k;      // Running column index of the sum
    logic busy;

    q16_t                          l_ik;
    q16_t                          l_jk;
    logic signed [2*WORD_BITS-1:0] prod;

    // On the diagonal both reads hit the same element, so this is a square
    assign l_ik = l_cur.elem[tri_idx(row, k)];
    assign l_jk = l_cur.elem[tri_idx(col, k)];
    assign prod = l_ik * l_jk;

    // Control
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= (req.col != 3'd0);
                done <= (req.col == 3'd0);  // Column 0 has nothing to subtract
            end else if (busy && (k == col - 3'd1)) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    // Accumulator
    // --------------------
    always_ff @(posedge clk) begin
        if (start) begin
            acc <= req.base;
            row <= req.row;
            col <= req.col;
            k   <= 3'd0;
        end else if (busy) begin
            acc <= acc - q16_t'(prod[FRAC_BITS +: WORD_BITS]);  // Truncated Q16.16 product
            k   <= k + 3'd1;
        end
    end

    assign result = acc;

endmodule

`default_nettype wire

// File: verilog/chol_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module chol_ctrl import chol_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  tri_mat_u a,
    input  logic     a_valid,
    output tri_mat_u l,
    output logic     l_valid,
    output logic     dot_start,
    output dot_req_t dot_req,
    input  logic     dot_done,
    input  q16_t     dot_result,
    output logic     sqrt_start,
    output q16_t     sqrt_operand,
    input  logic     sqrt_done,
    input  q16_t     sqrt_result,
    output logic     div_start,
    output q16_t     div_dividend,
    output q16_t     div_divisor,
    input  logic     div_done,
    input  q16_t     div_result
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_PIVOT,   // Diagonal reduction in the dot unit
        S_ROOT,    // Square root of the pivot
        S_REDUCE,  // Off-diagonal reduction
        S_DIVIDE,  // Divide by L_jj
        S_DONE     // Result held, ready for the next matrix
    } state_t;

    state_t   state;
    tri_mat_u a_mat;
    idx_t     col;
    idx_t     row;
    idx_t     col_nxt;
    idx_t     row_nxt;
    logic     last_col;
    logic     last_row;

    assign col_nxt  = col + 3'd1;
    assign row_nxt  = row + 3'd1;
    assign last_col = (col == idx_t'(MAT_N - 1));
    assign last_row = (row == idx_t'(MAT_N - 1));

    assign l_valid = (state == S_DONE);  // High from L_55 write until next accept

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= S_IDLE;
            col        <= '0;
            row        <= '0;
            l          <= '0;
            dot_start  <= 1'b0;
            sqrt_start <= 1'b0;
            div_start  <= 1'b0;
        end else begin
            dot_start  <= 1'b0;  // Single-cycle pulses
            sqrt_start <= 1'b0;
            div_start  <= 1'b0;

            case (state)
                S_IDLE, S_DONE: begin
                    if (a_valid) begin
                        a_mat     <= a;
                        l         <= '0;
                        col       <= '0;
                        row       <= '0;
                        dot_start <= 1'b1;
                        dot_req   <= '{base: a.elem[0], row: 3'd0, col: 3'd0};  // A_11
                        state     <= S_PIVOT;
                    end
                end

                S_PIVOT: begin
                    if (dot_done) begin
                        sqrt_start   <= 1'b1;
                        sqrt_operand <= dot_result;
                        state        <= S_ROOT;
                    end
                end

                S_ROOT: begin
                    if (sqrt_done) begin
                        l.elem[tri_idx(col, col)] <= sqrt_result;
                        if (last_col) begin
                            state <= S_DONE;
                        end else begin
                            // First element below the diagonal
                            row       <= col_nxt;
                            dot_start <= 1'b1;
                            dot_req   <= '{base: a_mat.elem[tri_idx(col_nxt, col)],
                                           row: col_nxt, col: col};
                            state     <= S_REDUCE;
                        end
                    end
                end

                S_REDUCE: begin
                    if (dot_done) begin
                        div_start    <= 1'b1;
                        div_dividend <= dot_result;
                        div_divisor  <= l.elem[tri_idx(col, col)];  // L_jj of this column
                        state        <= S_DIVIDE;
                    end
                end

                S_DIVIDE: begin
                    if (div_done) begin
                        l.elem[tri_idx(row, col)] <= div_result;
                        dot_start <= 1'b1;
                        if (last_row) begin
                            // Column finished, pivot of the next one
                            col     <= col_nxt;
                            row     <= col_nxt;
                            dot_req <= '{base: a_mat.elem[tri_idx(col_nxt, col_nxt)],
                                         row: col_nxt, col: col_nxt};
                            state   <= S_PIVOT;
                        end else begin
                            row     <= row_nxt;
                            dot_req <= '{base: a_mat.elem[tri_idx(row_nxt, col)],
                                         row: row_nxt, col: col};
                            state   <= S_REDUCE;
                        end
                    end
                end

                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/chol_top.sv
`timescale 1ns/1ns
`default_nettype none

module chol_top import chol_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  tri_mat_u a,
    input  logic     a_valid,
    output tri_mat_u l,
    output logic     l_valid
);

    // Dot-product unit
    logic     dot_start;
    dot_req_t dot_req;
    logic     dot_done;
    q16_t     dot_result;

    // Square root unit
    logic     sqrt_start;
    q16_t     sqrt_operand;
    logic     sqrt_done;
    q16_t     sqrt_result;

    // Divider
    logic     div_start;
    q16_t     div_dividend;
    q16_t     div_divisor;
    logic     div_done;
    q16_t     div_result;

    chol_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .a            (a),
        .a_valid      (a_valid),
        .l            (l),
        .l_valid      (l_valid),
        .dot_start    (dot_start),
        .dot_req      (dot_req),
        .dot_done     (dot_done),
        .dot_result   (dot_result),
        .sqrt_start   (sqrt_start),
        .sqrt_operand (sqrt_operand),
        .sqrt_done    (sqrt_done),
        .sqrt_result  (sqrt_result),
        .div_start    (div_start),
        .div_dividend (div_dividend),
        .div_divisor  (div_divisor),
        .div_done     (div_done),
        .div_result   (div_result)
    );

    chol_dot u_dot (
        .clk    (clk),
        .rst    (rst),
        .start  (dot_start),
        .req    (dot_req),
        .l_cur  (l),          // Live factor, earlier columns already final
        .done   (dot_done),
        .result (dot_result)
    );

    fix_sqrt u_sqrt (
        .clk     (clk),
        .rst     (rst),
        .start   (sqrt_start),
        .operand (sqrt_operand),
        .done    (sqrt_done),
        .result  (sqrt_result)
    );

    fix_div u_div (
        .clk      (clk),
        .rst      (rst),
        .start    (div_start),
        .dividend (div_dividend),
        .divisor  (div_divisor),
        .done     (div_done),
        .result   (div_result)
    );

endmodule

`default_nettype wire

// File: bench/chol_chk.sv
`timescale 1ns/1ns
`default_nettype none

module chol_chk import chol_pkg::*; (
    input logic     clk,
    input logic     rst,
    input logic     a_valid,
    input tri_mat_u l,
    input logic     l_valid,
    input logic     dot_start,
    input logic     sqrt_start,
    input logic     div_start,
    input logic     dot_done,
    input logic     sqrt_done,
    input logic     div_done
);

    logic any_start;
    logic pending;  // Some unit between its start and its done
    int   start_fails = 0;
    int   busy_fails  = 0;
    int   hold_fails  = 0;
    int   reset_fails = 0;
    int   assert_errors;

    assign any_start     = dot_start | sqrt_start | div_start;
    assign assert_errors = start_fails + busy_fails + hold_fails + reset_fails;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
        end else if (any_start) begin
            pending <= 1'b1;
        end else if (dot_done || sqrt_done || div_done) begin
            pending <= 1'b0;
        end
    end

    // Unit handshakes
    // --------------------
    single_start: assert property (@(posedge clk) disable iff (rst)
        $onehot0({dot_start, sqrt_start, div_start}))
        else begin
            start_fails++;
            $error("more than one unit started in one cycle");
        end

    start_when_free: assert property (@(posedge clk) disable iff (rst)
        any_start |-> !pending)
        else begin
            busy_fails++;
            $error("unit started while another one was still busy");
        end

    // Output port
    // --------------------
    result_held: assert property (@(posedge clk) disable iff (rst)
        (l_valid && !a_valid) |=> $stable(l))
        else begin
            hold_fails++;
            $error("l changed while l_valid was high");
        end

    valid_low_after_reset: assert property (@(posedge clk) rst |=> !l_valid)
        else begin
            reset_fails++;
            $error("l_valid high in the cycle after reset");
        end

endmodule

bind chol_ctrl chol_chk u_chk (
    .clk,
    .rst,
    .a_valid,
    .l,
    .l_valid,
    .dot_start,
    .sqrt_start,
    .div_start,
    .dot_done,
    .sqrt_done,
    .div_done
);

`default_nettype wire

// File: bench/chol_monitor.sv
`timescale 1ns/1ns
`default_nettype none

module chol_monitor import chol_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  tri_mat_u a,
    input  logic     a_valid,
    input  tri_mat_u l,
    input  logic     l_valid,
    input  int       num_cases,
    output int       mismatches,
    output int       protocol_errors,
    output int       results
);

    logic     busy;      // Accepted matrix whose factor is not out yet
    logic     seen;      // Any matrix accepted since reset
    logic     prev_lv;
    logic     prev_av;
    tri_mat_u prev_l;
    int       exp_case;

    // Case whose A words equal m, or -1
    function automatic int find_case(tri_mat_u m);
        int c;
        int e;
        int hit;
        hit = -1;
        for (c = 0; c < num_cases; c++) begin
            if (hit < 0) begin
                hit = c;
                for (e = 0; e < NUM_ELEMS; e++) begin
                    if (m.elem[e] !== tb_chol.cases[c*2*NUM_ELEMS + e]) begin
                        hit = -1;
                    end
                end
            end
        end
        return hit;
    endfunction

    task automatic compare_result(input int c);
        int   e;
        q16_t exp_w;
        for (e = 0; e < NUM_ELEMS; e++) begin
            exp_w = tb_chol.cases[c*2*NUM_ELEMS + NUM_ELEMS + e];
            if (l.elem[e] !== exp_w) begin
                mismatches++;
                $display("Mismatch l[%0d] case %0d: expected %h, actual %h",
                         e, c, exp_w, l.elem[e]);
            end
        end
    endtask

    always @(negedge clk) begin
        if (rst) begin
            busy            = 1'b0;
            seen            = 1'b0;
            prev_lv         = 1'b0;
            prev_av         = 1'b0;
            prev_l          = '0;
            exp_case        = -1;
            mismatches      = 0;
            protocol_errors = 0;
            results         = 0;
        end else begin
            if (!seen && l_valid) begin
                protocol_errors++;
                $display("l_valid is high before any matrix was given");
            end
            if (!seen && l.flat !== '0) begin
                mismatches++;
                $display("Mismatch l before first matrix: expected 0, actual %h", l.flat);
            end

            // Held output
            // --------------------
            if (prev_lv && !prev_av) begin
                if (!l_valid) begin
                    protocol_errors++;
                    $display("l_valid fell although no new matrix was given");
                end else if (l !== prev_l) begin
                    mismatches++;
                    $display("Mismatch l while held: expected %h, actual %h", prev_l.flat, l.flat);
                end
            end
            if (prev_lv && prev_av && l_valid) begin
                protocol_errors++;
                $display("l_valid stayed high after a new matrix was accepted");
            end

            if (l_valid && !prev_lv) begin
                if (!busy) begin
                    protocol_errors++;
                    $display("l_valid rose while no matrix was being factored");
                end else if (exp_case >= 0) begin
                    compare_result(exp_case);
                end
                results++;
                busy = 1'b0;
            end

            // DUT only takes a when it is not working on a matrix
            if (a_valid && !busy) begin
                exp_case = find_case(a);
                busy     = 1'b1;
                seen     = 1'b1;
                if (exp_case < 0) begin
                    protocol_errors++;
                    $display("Accepted matrix is not one of the known cases");
                end
            end

            prev_lv = l_valid;
            prev_av = a_valid;
            prev_l  = l;
        end
    end

endmodule

`default_nettype wire

// File: bench/tb_chol.sv
`timescale 1ns/1ns
`default_nettype none

module tb_chol import chol_pkg::*; ();

    localparam int NUM_CASES  = 4;
    localparam int CASE_WORDS = 2 * NUM_ELEMS;  // A words then expected L words
    localparam int TIMEOUT    = 2000;           // Cycles allowed per matrix

    logic     clk = 1'b0;
    logic     rst;
    tri_mat_u a;
    logic     a_valid;
    tri_mat_u l;
    logic     l_valid;

    logic [WORD_BITS-1:0] cases [0:NUM_CASES*CASE_WORDS-1];  // Monitor reads this too

    integer seed;
    int     mismatches;
    int     protocol_errors;
    int     results;
    int     assert_errors;
    int     total;
    logic   timed_out;

    always #50 clk = ~clk;

    chol_top DUT (
        .clk     (clk),
        .rst     (rst),
        .a       (a),
        .a_valid (a_valid),
        .l       (l),
        .l_valid (l_valid)
    );

    chol_monitor u_mon (
        .clk             (clk),
        .rst             (rst),
        .a               (a),
        .a_valid         (a_valid),
        .l               (l),
        .l_valid         (l_valid),
        .num_cases       (NUM_CASES),
        .mismatches      (mismatches),
        .protocol_errors (protocol_errors),
        .results         (results)
    );

    assign assert_errors = DUT.u_ctrl.u_chk.assert_errors;

    // One-cycle a_valid pulse carrying the A words of case c
    task automatic send_matrix(input int c);
        tri_mat_u m;
        int       e;
        for (e = 0; e < NUM_ELEMS; e++) begin
            m.elem[e] = cases[c*CASE_WORDS + e];
        end
        @(posedge clk);
        a       <= m;
        a_valid <= 1'b1;
        @(posedge clk);
        a_valid <= 1'b0;
    endtask

    task automatic wait_result(input int c);
        int n;
        n = 0;
        @(negedge clk);
        while (!l_valid && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!l_valid) begin
            timed_out = 1'b1;
            $display("DUT did not finish case %0d within %0d cycles", c, TIMEOUT);
        end
    endtask

    initial begin
        int c;
        int gap;
        seed      = 32'hcd933b5e;
        rst       = 1'b1;
        a         = '0;
        a_valid   = 1'b0;
        timed_out = 1'b0;
        $readmemh("bench/chol_cases.txt", cases);
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        repeat (5) @(posedge clk);  // Output must stay clear here

        for (c = 0; c < NUM_CASES && !timed_out; c++) begin
            send_matrix(c);
            if (c == 1) begin
                repeat (3) @(posedge clk);
                send_matrix(2);  // Must be dropped since the DUT is busy
            end
            wait_result(c);
            gap = $unsigned($random(seed)) % 4;
            repeat (gap) @(posedge clk);
        end

        // Result has to hold through these idle cycles
        repeat (10) @(posedge clk);
        total = mismatches + protocol_errors + assert_errors;
        if (timed_out) begin
            total++;
        end
        if (results != NUM_CASES) begin
            total++;
        end
        $display("Errors %0d (mismatch %0d, protocol %0d, assertion %0d), results %0d of %0d",
                 total, mismatches, protocol_errors, assert_errors, results, NUM_CASES);
        if (total == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/chol_cases.txt
// Each case has 15 A words and then 15 expected L words, 8 and 7 per line
// Words run in row order 11 21 22 31 32 33 41 to 55 as signed Q16.16 hex
// Diagonal matrix
00040000 00000000 00090000 00000000 00000000 00020000 00000000 00000000
00000000 00100000 00000000 00000000 00000000 00000000 00004000
00020000 00000000 00030000 00000000 00000000 00016A09 00000000 00000000
00000000 00040000 00000000 00000000 00000000 00000000 00008000
// Integer factor with negative entries
00040000 FFFE0000 000A0000 00020000 00050000 00090000 00000000 FFFA0000
FFFE0000 00060000 00060000 00000000 00030000 FFFF0000 001F0000
00020000 FFFF0000 00030000 00010000 00020000 00020000 00000000 FFFE0000
00010000 00010000 00030000 00010000 FFFF0000 00020000 00040000
// Factor in halves
00024000 0000C000 00044000 FFFE8000 00008000 00024000 0000C000 FFFD4000
FFFF4000 00090000 00000000 00020000 00000000 FFFF8000 00028000
00018000 00008000 00020000 FFFF0000 00008000 00010000 00008000 FFFE8000
00008000 00028000 00000000 00010000 FFFF8000 00008000 00010000
// Inexact root and quotient truncated toward zero
00020000 FFFF0000 00020000 00000000 00000000 00010000 00000000 00000000
00000000 00010000 00000000 00000000 00000000 00000000 00010000
00016A09 FFFF4AFB 00013988 00000000 00000000 00010000 00000000 00000000
00000000 00010000 00000000 00000000 00000000 00000000 00010000

// File: project.f
common/chol_pkg.sv
arith/fix_sqrt.sv
arith/fix_div.sv
verilog/chol_dot.sv
verilog/chol_ctrl.sv
verilog/chol_top.sv
bench/chol_chk.sv
bench/chol_monitor.sv
bench/tb_chol.sv

// File: Makefile
TOP = tb_chol

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f project.f
	./obj_dir/V$(TOP) +verilator+error+limit+1000 > sim.log 2>&1; cat sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
